//--- design/dma_datapath.sv
// DMA data path between 32 bit host and 64 bit memory sides
// to memory: dword pairs packed low half first into the qword FIFO
// from memory: each qword split into two dword FIFO entries

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module dma_datapath (
    input  logic                   sclk,
    input  logic                   reset,
    input  sata_dma_pkg::dma_dir_t dir,
    // host side
    input  sata_dma_pkg::dword_t   in_data,
    input  logic                   in_val,
    output logic                   in_busy,
    output sata_dma_pkg::dword_t   out_data,
    output logic                   out_val,
    input  logic                   out_busy,
    // memory side
    output sata_dma_pkg::qword_t   to_data,
    output logic                   to_val,
    input  logic                   to_ack,
    input  sata_dma_pkg::qword_t   from_data,
    input  logic                   from_val,
    output logic                   from_ack,
    // to the counter and sequencer
    output logic                   beat,
    output logic                   idle
);

    sata_dma_pkg::dword_t lo_dword;     // first dword of a pair
    logic                 lo_valid;
    sata_dma_pkg::dword_t hi_dword;     // upper half still to push
    logic                 hi_valid;
    logic                 in_take;
    logic                 from_take;
    logic                 q_full;
    logic                 q_empty;
    logic                 d_push;
    sata_dma_pkg::dword_t d_wdata;
    logic                 d_full;
    logic                 d_empty;

    // packer, a dword is always taken while the pair is incomplete
    assign in_busy = (dir != sata_dma_pkg::DIR_TO_MEM) || (lo_valid && q_full);
    assign in_take = in_val && !in_busy;

    always_ff @(posedge sclk) begin
        if (reset) lo_valid <= 1'b0;
        else if (in_take) lo_valid <= !lo_valid;
    end

    always_ff @(posedge sclk) begin
        if (in_take && !lo_valid) lo_dword <= in_data;
    end

    dma_fifo #(.T(sata_dma_pkg::qword_t)) i_qword_fifo (
        .sclk   (sclk),
        .reset  (reset),
        .push   (in_take && lo_valid),
        .wdata  ({in_data, lo_dword}),
        .pop    (to_val && to_ack),
        .rdata  (to_data),
        .full   (q_full),
        .empty  (q_empty)
    );

    assign to_val = !q_empty;

    // unpacker, low half goes straight in and the high half follows
    assign from_ack  = (dir == sata_dma_pkg::DIR_FROM_MEM) && !hi_valid && !d_full;
    assign from_take = from_val && from_ack;
    assign d_push    = from_take || (hi_valid && !d_full);
    assign d_wdata   = hi_valid ? hi_dword : from_data[`DWORD_W-1:0];

    always_ff @(posedge sclk) begin
        if (reset) hi_valid <= 1'b0;
        else if (from_take) hi_valid <= 1'b1;
        else if (!d_full) hi_valid <= 1'b0;
    end

    always_ff @(posedge sclk) begin
        if (from_take) hi_dword <= from_data[`QWORD_W-1:`DWORD_W];
    end

    dma_fifo #(.T(sata_dma_pkg::dword_t)) i_dword_fifo (
        .sclk   (sclk),
        .reset  (reset),
        .push   (d_push),
        .wdata  (d_wdata),
        .pop    (out_val && !out_busy),
        .rdata  (out_data),
        .full   (d_full),
        .empty  (d_empty)
    );

    assign out_val = !d_empty;

    assign beat = (to_val && to_ack) || from_take;
    assign idle = q_empty && d_empty && !lo_valid && !hi_valid;

endmodule

//--- design/dma_fifo.sv
// synchronous FIFO, FIFO_DEPTH entries of any payload type
// first word shows on rdata while not empty

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module dma_fifo #(
    parameter type T = logic [31:0]
) (
    input  logic sclk,
    input  logic reset,
    input  logic push,
    input  T     wdata,
    input  logic pop,
    output T     rdata,
    output logic full,
    output logic empty
);

    localparam int AW = $clog2(`FIFO_DEPTH);

    T              mem [`FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign full    = (count == (AW+1)'(`FIFO_DEPTH));
    assign empty   = (count == '0);
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge sclk) begin
        if (do_push) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge sclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

endmodule

//--- design/dma_fsm.sv
// DMA transfer sequencer
// one command to the SATA host, then one adapter command per 128 byte chunk,
// each waiting for the previous chunk's beats; done once the datapath drains

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module dma_fsm (
    input  logic            sclk,
    input  logic            reset,
    dma_req_if.target       req,
    host_cmd_if.initiator   host,
    adp_cmd_if.initiator    adp,
    input  logic            chunk_done,
    input  logic            xfer_last,
    input  logic            dp_idle,
    output logic            cnt_load
);

    sata_dma_pkg::dma_state_t  state;
    sata_dma_pkg::chunk_addr_t chunk_addr;
    sata_dma_pkg::dma_dir_t    dir_r;
    logic                      chunk_pend;  // chunk end seen before reaching XFER
    logic                      last_pend;
    logic                      chunk_hit;
    logic                      last_hit;
    logic                      start;

    assign start     = (state == sata_dma_pkg::IDLE) && req.dma_start;
    assign chunk_hit = chunk_done || chunk_pend;
    assign last_hit  = (chunk_done && xfer_last) || last_pend;
    assign cnt_load  = start;

    // handshakes follow the state directly
    assign host.host_new_cmd = (state == sata_dma_pkg::HOST_CMD) && host.host_ready_for_cmd;
    assign adp.adp_val       = (state == sata_dma_pkg::ADP_CMD) && !adp.adp_busy;
    assign adp.adp_addr      = chunk_addr;
    assign adp.adp_type      = dir_r;
    assign req.dma_done      = (state == sata_dma_pkg::FLUSH) && dp_idle;

    always_ff @(posedge sclk) begin
        if (reset) begin
            state      <= sata_dma_pkg::IDLE;
            chunk_pend <= 1'b0;
            last_pend  <= 1'b0;
        end else begin
            case (state)
                sata_dma_pkg::IDLE:
                    if (req.dma_start) state <= sata_dma_pkg::HOST_CMD;
                sata_dma_pkg::HOST_CMD:
                    if (host.host_new_cmd) state <= sata_dma_pkg::ADP_CMD;
                sata_dma_pkg::ADP_CMD:
                    if (adp.adp_val) state <= sata_dma_pkg::XFER;
                sata_dma_pkg::XFER:
                    if (chunk_hit) begin
                        state <= last_hit ? sata_dma_pkg::FLUSH : sata_dma_pkg::ADP_CMD;
                    end
                sata_dma_pkg::FLUSH:
                    if (dp_idle) state <= sata_dma_pkg::IDLE;
                default:
                    state <= sata_dma_pkg::IDLE;
            endcase

            // XFER consumes chunk ends itself
            if (state == sata_dma_pkg::XFER || state == sata_dma_pkg::IDLE) begin
                chunk_pend <= 1'b0;
                last_pend  <= 1'b0;
            end else if (chunk_done) begin
                chunk_pend <= 1'b1;
                last_pend  <= xfer_last;
            end
        end
    end

    // command fields captured at start
    always_ff @(posedge sclk) begin
        if (start) begin
            chunk_addr              <= req.mem_address[`DWORD_W-1:`DWORD_W-`CHUNK_ADDR_W];
            dir_r                   <= req.dir;
            host.host_sector_addr   <= req.lba;
            host.host_sector_count  <= req.sector_cnt;
            host.host_cmd_type      <= (req.dir == sata_dma_pkg::DIR_TO_MEM) ?
                                       `HOST_CMD_READ_DMA : `HOST_CMD_WRITE_DMA;
        end else if (state == sata_dma_pkg::XFER && chunk_hit) begin
            chunk_addr <= chunk_addr + 1'b1;    // next 128 bytes
        end
    end

endmodule

//--- design/dma_regs.sv
// DMA register file
// memory address, LBA, sector count and control, plus busy/done status

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module dma_regs (
    input  logic                    sclk,
    input  logic                    reset,
    input  logic [`REG_ADDR_W-1:0]  reg_addr,
    input  sata_dma_pkg::dword_t    reg_wdata,
    input  logic                    reg_wen,
    input  logic                    reg_ren,
    output sata_dma_pkg::dword_t    reg_rdata,
    dma_req_if.initiator            req
);

    sata_dma_pkg::dword_t mem_address_r;
    sata_dma_pkg::dword_t lba_r;
    sata_dma_pkg::dword_t sector_cnt_r;
    sata_dma_pkg::dword_t control_r;    // bit 0 direction, bit 1 start
    sata_dma_pkg::dword_t rd_mux;
    logic                 busy;
    logic                 done;

    assign req.mem_address = mem_address_r;
    assign req.lba         = lba_r;
    assign req.sector_cnt  = sector_cnt_r;
    assign req.dir         = sata_dma_pkg::dma_dir_t'(control_r[0]);

    always_ff @(posedge sclk) begin
        if (reset) begin
            mem_address_r <= '0;
            lba_r         <= '0;
            sector_cnt_r  <= '0;
            control_r     <= '0;
            req.dma_start <= 1'b0;
            busy          <= 1'b0;
            done          <= 1'b0;
        end else begin
            // start goes out the cycle after the control write
            req.dma_start <= reg_wen && (reg_addr == `REG_CONTROL) && reg_wdata[1];
            if (reg_wen) begin
                case (reg_addr)
                    `REG_MEM_ADDR:   mem_address_r <= reg_wdata;
                    `REG_LBA:        lba_r         <= reg_wdata;
                    `REG_SECTOR_CNT: sector_cnt_r  <= reg_wdata;
                    `REG_CONTROL:    control_r     <= reg_wdata;
                    default: ;      // status is read only
                endcase
            end
            if (req.dma_start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (req.dma_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            `REG_MEM_ADDR:   rd_mux = mem_address_r;
            `REG_LBA:        rd_mux = lba_r;
            `REG_SECTOR_CNT: rd_mux = sector_cnt_r;
            `REG_CONTROL:    rd_mux = control_r;
            `REG_STATUS:     rd_mux = sata_dma_pkg::dword_t'({done, busy});
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge sclk) begin
        if (reg_ren) reg_rdata <= rd_mux;   // valid one cycle after ren
    end

endmodule

//--- design/dma_xfer_counter.sv
// beat and chunk counter
// counts memory side qwords per chunk and the chunks left in a transfer

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module dma_xfer_counter (
    input  logic                 sclk,
    input  logic                 reset,
    input  logic                 load,
    input  sata_dma_pkg::dword_t sector_cnt,
    input  logic                 beat,
    output logic                 chunk_done,
    output logic                 xfer_last
);

    localparam int BEAT_W = $clog2(`QWORDS_PER_CHUNK);

    logic [BEAT_W-1:0]    beat_cnt;
    sata_dma_pkg::dword_t chunks_left;

    assign chunk_done = beat && (beat_cnt == BEAT_W'(`QWORDS_PER_CHUNK - 1));
    assign xfer_last  = (chunks_left == 32'd1);     // current chunk is the final one

    always_ff @(posedge sclk) begin
        if (reset) begin
            beat_cnt    <= '0;
            chunks_left <= '0;
        end else if (load) begin
            beat_cnt    <= '0;
            chunks_left <= sata_dma_pkg::dword_t'(sector_cnt * `CHUNKS_PER_SECTOR);
        end else begin
            if (beat) beat_cnt <= beat_cnt + 1'b1;  // wraps at chunk end
            if (chunk_done && chunks_left != '0) chunks_left <= chunks_left - 1'b1;
        end
    end

endmodule

//--- design/sata_dma_defines.svh
// shared widths, register map and command codes for the SATA DMA core
// memory side moves qwords, host side moves dwords

`ifndef SATA_DMA_DEFINES_SVH
`define SATA_DMA_DEFINES_SVH

`define DWORD_W             32
`define QWORD_W             64
`define CHUNK_ADDR_W        25      // address bits 31..7
`define QWORDS_PER_CHUNK    16      // 128 bytes per adapter command
`define CHUNKS_PER_SECTOR   4       // 512 byte sector

// register map
`define REG_ADDR_W          3
`define REG_MEM_ADDR        3'd0
`define REG_LBA             3'd1
`define REG_SECTOR_CNT      3'd2
`define REG_CONTROL         3'd3
`define REG_STATUS          3'd4

// host command codes
`define HOST_CMD_READ_DMA   2'd1    // device to memory
`define HOST_CMD_WRITE_DMA  2'd2    // memory to device

`define FIFO_DEPTH          8

`endif

//--- design/sata_dma_ifs.sv
// interfaces between the DMA register file, sequencer, host and adapter
// register block -> sequencer, sequencer -> host and sequencer -> adapter

`timescale 1ns/10ps

interface dma_req_if;
    sata_dma_pkg::dword_t   mem_address;
    sata_dma_pkg::dword_t   lba;
    sata_dma_pkg::dword_t   sector_cnt;
    sata_dma_pkg::dma_dir_t dir;
    logic                   dma_start;  // one cycle
    logic                   dma_done;   // one cycle

    modport initiator (output mem_address, lba, sector_cnt, dir, dma_start, input dma_done);
    modport target    (input mem_address, lba, sector_cnt, dir, dma_start, output dma_done);
endinterface

interface host_cmd_if;
    logic                 host_ready_for_cmd;
    logic                 host_new_cmd;
    logic [1:0]           host_cmd_type;
    sata_dma_pkg::dword_t host_sector_count;
    sata_dma_pkg::dword_t host_sector_addr;

    modport initiator (
        input  host_ready_for_cmd,
        output host_new_cmd, host_cmd_type, host_sector_count, host_sector_addr
    );
    modport target (
        output host_ready_for_cmd,
        input  host_new_cmd, host_cmd_type, host_sector_count, host_sector_addr
    );
endinterface

interface adp_cmd_if;
    logic                      adp_busy;
    sata_dma_pkg::chunk_addr_t adp_addr;
    logic                      adp_type;   // same encoding as dma_dir_t
    logic                      adp_val;

    modport initiator (input adp_busy, output adp_addr, adp_type, adp_val);
    modport target    (output adp_busy, input adp_addr, adp_type, adp_val);
endinterface

//--- design/sata_dma_pkg.sv
// SATA DMA types
// data words, chunk address, direction and sequencer states

`include "sata_dma_defines.svh"

package sata_dma_pkg;

    typedef logic [`DWORD_W-1:0]      dword_t;       // host side word
    typedef logic [`QWORD_W-1:0]      qword_t;       // memory side word
    typedef logic [`CHUNK_ADDR_W-1:0] chunk_addr_t;  // 128 byte granule

    // DIR_TO_MEM reads the device into memory
    typedef enum logic {
        DIR_TO_MEM   = 1'b0,
        DIR_FROM_MEM = 1'b1
    } dma_dir_t;

    typedef enum logic [2:0] {
        IDLE,
        HOST_CMD,   // waiting for the host to take the command
        ADP_CMD,    // chunk command to the memory adapter
        XFER,       // chunk data in flight
        FLUSH       // draining the datapath
    } dma_state_t;

endpackage

//--- design/sata_dma_top.sv
// SATA DMA core top level
// register port, host and adapter command ports, and the four data ports

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module sata_dma_top (
    input  logic                      sclk,
    input  logic                      reset,
    // register port
    input  logic [`REG_ADDR_W-1:0]    reg_addr,
    input  sata_dma_pkg::dword_t      reg_wdata,
    input  logic                      reg_wen,
    input  logic                      reg_ren,
    output sata_dma_pkg::dword_t      reg_rdata,
    // sata host command
    input  logic                      host_ready_for_cmd,
    output logic                      host_new_cmd,
    output logic [1:0]                host_cmd_type,
    output sata_dma_pkg::dword_t      host_sector_count,
    output sata_dma_pkg::dword_t      host_sector_addr,
    // memory adapter command
    input  logic                      adp_busy,
    output sata_dma_pkg::chunk_addr_t adp_addr,
    output logic                      adp_type,
    output logic                      adp_val,
    // data
    output sata_dma_pkg::qword_t      to_data,
    output logic                      to_val,
    input  logic                      to_ack,
    input  sata_dma_pkg::qword_t      from_data,
    input  logic                      from_val,
    output logic                      from_ack,
    input  sata_dma_pkg::dword_t      in_data,
    input  logic                      in_val,
    output logic                      in_busy,
    output sata_dma_pkg::dword_t      out_data,
    output logic                      out_val,
    input  logic                      out_busy
);

    dma_req_if  req_if ();
    host_cmd_if host_if ();
    adp_cmd_if  adp_if ();

    logic chunk_done;
    logic xfer_last;
    logic dp_idle;
    logic cnt_load;
    logic beat;

    assign host_if.host_ready_for_cmd = host_ready_for_cmd;
    assign host_new_cmd               = host_if.host_new_cmd;
    assign host_cmd_type              = host_if.host_cmd_type;
    assign host_sector_count          = host_if.host_sector_count;
    assign host_sector_addr           = host_if.host_sector_addr;

    assign adp_if.adp_busy = adp_busy;
    assign adp_addr        = adp_if.adp_addr;
    assign adp_type        = adp_if.adp_type;
    assign adp_val         = adp_if.adp_val;

    dma_regs i_dma_regs (
        .sclk       (sclk),
        .reset      (reset),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_wen    (reg_wen),
        .reg_ren    (reg_ren),
        .reg_rdata  (reg_rdata),
        .req        (req_if.initiator)
    );

    dma_fsm i_dma_fsm (
        .sclk       (sclk),
        .reset      (reset),
        .req        (req_if.target),
        .host       (host_if.initiator),
        .adp        (adp_if.initiator),
        .chunk_done (chunk_done),
        .xfer_last  (xfer_last),
        .dp_idle    (dp_idle),
        .cnt_load   (cnt_load)
    );

    dma_xfer_counter i_dma_xfer_counter (
        .sclk       (sclk),
        .reset      (reset),
        .load       (cnt_load),
        .sector_cnt (req_if.sector_cnt),
        .beat       (beat),
        .chunk_done (chunk_done),
        .xfer_last  (xfer_last)
    );

    dma_datapath i_dma_datapath (
        .sclk       (sclk),
        .reset      (reset),
        .dir        (req_if.dir),
        .in_data    (in_data),
        .in_val     (in_val),
        .in_busy    (in_busy),
        .out_data   (out_data),
        .out_val    (out_val),
        .out_busy   (out_busy),
        .to_data    (to_data),
        .to_val     (to_val),
        .to_ack     (to_ack),
        .from_data  (from_data),
        .from_val   (from_val),
        .from_ack   (from_ack),
        .beat       (beat),
        .idle       (dp_idle)
    );

endmodule

//--- verification/sata_dma_tb.sv
// testbench for the SATA DMA core
// random host, adapter and data responders with a reference packing model

`timescale 1ns/10ps
`include "sata_dma_defines.svh"

module sata_dma_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int TOTAL_SECTORS = 5;   // 1 + 2 to memory, 2 from memory
    localparam int WATCHDOG_NS   = (TOTAL_SECTORS * 128 * 8 + 2000) * CLK_PERIOD;

    logic                      sclk;
    logic                      reset;
    logic [`REG_ADDR_W-1:0]    reg_addr;
    sata_dma_pkg::dword_t      reg_wdata;
    logic                      reg_wen;
    logic                      reg_ren;
    sata_dma_pkg::dword_t      reg_rdata;
    logic                      host_ready_for_cmd;
    logic                      host_new_cmd;
    logic [1:0]                host_cmd_type;
    sata_dma_pkg::dword_t      host_sector_count;
    sata_dma_pkg::dword_t      host_sector_addr;
    logic                      adp_busy;
    sata_dma_pkg::chunk_addr_t adp_addr;
    logic                      adp_type;
    logic                      adp_val;
    sata_dma_pkg::qword_t      to_data;
    logic                      to_val;
    logic                      to_ack;
    sata_dma_pkg::qword_t      from_data;
    logic                      from_val;
    logic                      from_ack;
    sata_dma_pkg::dword_t      in_data;
    logic                      in_val;
    logic                      in_busy;
    sata_dma_pkg::dword_t      out_data;
    logic                      out_val;
    logic                      out_busy;

    sata_dma_pkg::dword_t      in_words [256];     // host dwords, up to 2 sectors
    sata_dma_pkg::qword_t      from_words [128];   // memory qwords, up to 2 sectors
    int                        in_idx;
    int                        in_count;
    int                        from_idx;
    int                        from_count;
    logic                      in_taken;
    logic                      from_taken;
    int                        host_seen;
    int                        adp_seen;
    int                        to_seen;
    int                        out_seen;
    sata_dma_pkg::dma_dir_t    cur_dir;
    sata_dma_pkg::dword_t      cur_mem_addr;
    sata_dma_pkg::dword_t      cur_lba;
    sata_dma_pkg::dword_t      cur_sectors;
    string                     cur_test;
    int                        test_errors;
    int                        total_errors;
    int                        tests_run;
    int                        tests_failed;
    logic [31:0]               rng;
    logic [31:0]               bp_bits;

    sata_dma_top i_sata_dma_top (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // expected word idx as a packed qword or as a dword in the low half
    function automatic sata_dma_pkg::qword_t expected_word(input sata_dma_pkg::dma_dir_t dir,
                                                           input int idx);
        if (dir == sata_dma_pkg::DIR_TO_MEM)
            return {in_words[2*idx+1], in_words[2*idx]};   // first dword is the low half
        if (idx % 2 == 0)
            return {32'd0, from_words[idx/2][31:0]};
        return {32'd0, from_words[idx/2][63:32]};
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Fail %s: %s expected %h actual %h", cur_test, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr, input sata_dma_pkg::dword_t data);
        @(posedge sclk);
        #1;
        reg_addr  = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        @(posedge sclk);
        #1;
        reg_wen = 1'b0;
    endtask

    task automatic read_reg(input logic [`REG_ADDR_W-1:0] addr,
                            output sata_dma_pkg::dword_t data);
        @(posedge sclk);
        #1;
        reg_addr = addr;
        reg_ren  = 1'b1;
        @(posedge sclk);
        #1;
        reg_ren = 1'b0;
        data    = reg_rdata;    // registered the edge before
    endtask

    task automatic expect_reg(input logic [`REG_ADDR_W-1:0] addr,
                              input sata_dma_pkg::dword_t expected, input string what);
        sata_dma_pkg::dword_t value;
        read_reg(addr, value);
        if (value !== expected) report_mismatch(what, expected, value);
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: passed", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic check_registers();
        cur_test = "register_readback";
        if (host_new_cmd !== 1'b0 || adp_val !== 1'b0 || to_val !== 1'b0 ||
            from_ack !== 1'b0 || out_val !== 1'b0 || in_busy !== 1'b0)
            report_problem("an output is not low after reset");
        expect_reg(`REG_STATUS, 32'd0, "status after reset");
        write_reg(`REG_MEM_ADDR, 32'h8000_1f80);
        write_reg(`REG_LBA, 32'h0012_3456);
        write_reg(`REG_SECTOR_CNT, 32'd3);
        write_reg(`REG_CONTROL, 32'h1);     // sets direction without start
        expect_reg(`REG_MEM_ADDR, 32'h8000_1f80, "mem address");
        expect_reg(`REG_LBA, 32'h0012_3456, "lba");
        expect_reg(`REG_SECTOR_CNT, 32'd3, "sector count");
        expect_reg(`REG_CONTROL, 32'h1, "control");
        expect_reg(`REG_STATUS, 32'd0, "status without start");
        finish_test();
    endtask

    task automatic run_transfer(input string name, input sata_dma_pkg::dma_dir_t dir,
                                input int sectors, input sata_dma_pkg::dword_t mem_addr,
                                input sata_dma_pkg::dword_t lba);
        sata_dma_pkg::dword_t status;
        int polls;
        int i;
        @(negedge sclk);
        cur_test     = name;
        cur_dir      = dir;
        cur_mem_addr = mem_addr;
        cur_lba      = lba;
        cur_sectors  = sectors;
        host_seen    = 0;
        adp_seen     = 0;
        to_seen      = 0;
        out_seen     = 0;
        for (i = 0; i < 256; i++) in_words[i] = next_rand();
        for (i = 0; i < 128; i++) from_words[i] = {next_rand(), next_rand()};
        write_reg(`REG_MEM_ADDR, mem_addr);
        write_reg(`REG_LBA, lba);
        write_reg(`REG_SECTOR_CNT, sectors);
        write_reg(`REG_CONTROL, {30'd0, 1'b1, dir});    // start plus direction
        @(negedge sclk);
        // data only after the counter has loaded
        in_idx     = 0;
        from_idx   = 0;
        in_count   = (dir == sata_dma_pkg::DIR_TO_MEM) ? sectors * 128 : 0;
        from_count = (dir == sata_dma_pkg::DIR_FROM_MEM) ? sectors * 64 : 0;
        read_reg(`REG_STATUS, status);
        if (status[1:0] !== 2'b01) report_mismatch("status after start", 64'h1, status);
        polls = 0;
        while (status[1] !== 1'b1 && polls < sectors * 1024) begin
            read_reg(`REG_STATUS, status);
            polls++;
        end
        if (status[1] !== 1'b1)
            report_problem("transfer did not complete, done never set");
        else if (status[0] !== 1'b0)
            report_problem("busy still set after done");
        if (host_seen != 1) report_mismatch("host command count", 1, host_seen);
        if (adp_seen != sectors * 4) report_mismatch("adapter command count", sectors * 4, adp_seen);
        if (dir == sata_dma_pkg::DIR_TO_MEM && to_seen != sectors * 64)
            report_mismatch("to port beats", sectors * 64, to_seen);
        if (dir == sata_dma_pkg::DIR_FROM_MEM && out_seen != sectors * 128)
            report_mismatch("out port dwords", sectors * 128, out_seen);
        if (in_idx != in_count) report_mismatch("host dwords taken", in_count, in_idx);
        if (from_idx != from_count) report_mismatch("memory qwords taken", from_count, from_idx);
        @(negedge sclk);
        in_count   = 0;
        from_count = 0;
        finish_test();
    endtask

    initial begin
        sclk = 1'b0;
        forever #(CLK_PERIOD/2) sclk = ~sclk;
    end

    // responders and data sources drive just after each rising edge
    always @(posedge sclk) begin
        #1;
        bp_bits = next_rand();
        if (in_taken) in_idx++;
        if (from_taken) from_idx++;
        host_ready_for_cmd = bp_bits[0] | bp_bits[1];
        adp_busy           = bp_bits[2] & bp_bits[3];
        to_ack             = bp_bits[4] & bp_bits[5];   // sparse so the qword FIFO fills
        out_busy           = bp_bits[6] & bp_bits[7];
        in_val             = (in_idx < in_count) && (bp_bits[8] | bp_bits[9]);
        in_data            = in_words[in_idx % 256];
        from_val           = (from_idx < from_count) && (bp_bits[10] | bp_bits[11]);
        from_data          = from_words[from_idx % 128];
    end

    // every handshake is sampled mid cycle and compared with the reference
    always @(negedge sclk) begin : compare_outputs
        sata_dma_pkg::chunk_addr_t exp_chunk;
        sata_dma_pkg::qword_t      exp_word;
        logic [1:0]                exp_cmd;
        in_taken   = in_val && !in_busy;
        from_taken = from_val && from_ack;
        if (!reset) begin
            if (host_new_cmd) begin
                exp_cmd = (cur_dir == sata_dma_pkg::DIR_TO_MEM) ?
                          `HOST_CMD_READ_DMA : `HOST_CMD_WRITE_DMA;
                if (host_sector_addr !== cur_lba)
                    report_mismatch("host lba", cur_lba, host_sector_addr);
                if (host_sector_count !== cur_sectors)
                    report_mismatch("host sector count", cur_sectors, host_sector_count);
                if (host_cmd_type !== exp_cmd)
                    report_mismatch("host command type", exp_cmd, host_cmd_type);
                host_seen++;
            end
            if (adp_val) begin
                exp_chunk = cur_mem_addr[31:7] + 25'(adp_seen);   // one per 128 bytes
                if (adp_addr !== exp_chunk)
                    report_mismatch($sformatf("adapter address %0d", adp_seen),
                                    exp_chunk, adp_addr);
                if (adp_type !== logic'(cur_dir))
                    report_mismatch("adapter type", cur_dir, adp_type);
                adp_seen++;
            end
            if (to_val && to_ack) begin
                if (cur_dir != sata_dma_pkg::DIR_TO_MEM || to_seen >= cur_sectors * 64) begin
                    report_problem("unexpected beat on the to port");
                end else begin
                    exp_word = expected_word(cur_dir, to_seen);
                    if (to_data !== exp_word)
                        report_mismatch($sformatf("to beat %0d", to_seen), exp_word, to_data);
                end
                to_seen++;
            end
            if (out_val && !out_busy) begin
                if (cur_dir != sata_dma_pkg::DIR_FROM_MEM || out_seen >= cur_sectors * 128) begin
                    report_problem("unexpected dword on the out port");
                end else begin
                    exp_word = expected_word(cur_dir, out_seen);
                    if (out_data !== exp_word[31:0])
                        report_mismatch($sformatf("out dword %0d", out_seen), exp_word, out_data);
                end
                out_seen++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset              = 1'b1;
        reg_addr           = '0;
        reg_wdata          = '0;
        reg_wen            = 1'b0;
        reg_ren            = 1'b0;
        host_ready_for_cmd = 1'b0;
        adp_busy           = 1'b0;
        to_ack             = 1'b0;
        from_data          = '0;
        from_val           = 1'b0;
        in_data            = '0;
        in_val             = 1'b0;
        out_busy           = 1'b0;
        in_idx             = 0;
        in_count           = 0;
        from_idx           = 0;
        from_count         = 0;
        in_taken           = 1'b0;
        from_taken         = 1'b0;
        cur_dir            = sata_dma_pkg::DIR_TO_MEM;
        cur_test           = "reset";
        test_errors        = 0;
        total_errors       = 0;
        tests_run          = 0;
        tests_failed       = 0;
        rng                = 32'd51169;
        repeat (3) @(posedge sclk);
        #1;
        reset = 1'b0;

        check_registers();
        run_transfer("to_mem_1_sector", sata_dma_pkg::DIR_TO_MEM, 1,
                     32'h1000_0000, 32'h0000_0100);
        run_transfer("to_mem_2_sectors", sata_dma_pkg::DIR_TO_MEM, 2,
                     32'h2345_6780, 32'h0001_0000);
        run_transfer("from_mem_2_sectors", sata_dma_pkg::DIR_FROM_MEM, 2, 32'h7fff_ff00,
                     32'h00ab_cdef);     // chunk address carries across bit 31

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (tests_failed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/sata_dma_pkg.sv
design/sata_dma_ifs.sv
design/dma_regs.sv
design/dma_fsm.sv
design/dma_xfer_counter.sv
design/dma_fifo.sv
design/dma_datapath.sv
design/sata_dma_top.sv
verification/sata_dma_tb.sv
